// File: cpu_pkg.sv
package cpu_pkg;

    // Data word and byte address share one width
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // Major opcodes of the supported RV32I subset
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rd1;
        word_t     rd2;
        word_t     imm;
        alu_op_e   alu_op;
        logic      alu_src_imm;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        logic      branch;
        logic      branch_ne;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     alu_result;
        word_t     store_data;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     wb_data;
        logic      reg_write;
    } mem_wb_t;

endpackage

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import cpu_pkg::*;
#(
    parameter int IMEM_DEPTH = 256
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   run,
    input  logic   stall,
    input  logic   flush,
    input  word_t  branch_target,
    input  logic   imem_we,
    input  word_t  imem_addr,
    input  word_t  imem_data,
    output if_id_t if_id
);

    localparam int IA_W = $clog2(IMEM_DEPTH);

    word_t imem [IMEM_DEPTH];
    word_t pc;
    word_t inst;

    // Preload address is a byte address, low two bits dropped
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr[IA_W+1:2]] <= imem_data;
        end
    end

    assign inst = imem[pc[IA_W+1:2]];

    // Redirect wins over a hold
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (flush) begin
            pc <= branch_target;
        end else if (run && !stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (flush || !stall) begin
            if_id.pc    <= pc;
            if_id.instr <= inst;
        end
        // Bubble while halted or when squashed by a taken branch
        if (rst || flush) begin
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            if_id.valid <= run;
        end
    end

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  logic    stall,
    input  if_id_t  if_id,
    input  mem_wb_t mem_wb,
    output id_ex_t  id_ex
);

    opcode_t   opcode;
    logic [2:0] funct3;
    logic      funct7_b5;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_u;
    word_t     regs [32];
    word_t     rd1;
    word_t     rd2;
    logic      wb_en;
    id_ex_t    dec;

    assign opcode    = if_id.instr[6:0];
    assign funct3    = if_id.instr[14:12];
    assign funct7_b5 = if_id.instr[30];
    assign rs1       = if_id.instr[19:15];
    assign rs2       = if_id.instr[24:20];
    assign rd        = if_id.instr[11:7];

    assign imm_i = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
    assign imm_s = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
    assign imm_b = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
                    if_id.instr[30:25], if_id.instr[11:8], 1'b0};
    assign imm_u = {if_id.instr[31:12], 12'b0};

    // Writeback port never stores x0
    assign wb_en = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[mem_wb.rd] <= mem_wb.wb_data;
        end
    end

    // Same-cycle writeback is visible to the reader
    assign rd1 = (rs1 == '0) ? '0 :
                 (wb_en && mem_wb.rd == rs1) ? mem_wb.wb_data : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 :
                 (wb_en && mem_wb.rd == rs2) ? mem_wb.wb_data : regs[rs2];

    always_comb begin
        dec        = '0;
        dec.valid  = if_id.valid;
        dec.pc     = if_id.pc;
        dec.rs1    = rs1;
        dec.rs2    = rs2;
        dec.rd     = rd;
        dec.rd1    = rd1;
        dec.rd2    = rd2;
        dec.alu_op = ALU_ADD;
        case (opcode)
            OP_IMM: begin
                // Only ADDI
                if (funct3 == 3'b000) begin
                    dec.imm         = imm_i;
                    dec.alu_src_imm = 1'b1;
                    dec.reg_write   = 1'b1;
                end
            end
            OP_LUI: begin
                dec.imm         = imm_u;
                dec.alu_op      = ALU_PASS_B;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
            end
            OP_REG: begin
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = funct7_b5 ? ALU_SUB : ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OP_LOAD: begin
                if (funct3 == 3'b010) begin
                    dec.imm         = imm_i;
                    dec.alu_src_imm = 1'b1;
                    dec.mem_read    = 1'b1;
                    dec.reg_write   = 1'b1;
                end
            end
            OP_STORE: begin
                if (funct3 == 3'b010) begin
                    dec.imm         = imm_s;
                    dec.alu_src_imm = 1'b1;
                    dec.mem_write   = 1'b1;
                end
            end
            OP_BRANCH: begin
                dec.imm       = imm_b;
                dec.branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
                dec.branch_ne = (funct3 == 3'b001);
            end
            default: begin
                dec.alu_op = ALU_ADD;
            end
        endcase
    end

    // Stall and flush both leave a bubble in ID/EX
    always_ff @(posedge clk) begin
        id_ex <= dec;
        if (rst || stall || flush) begin
            id_ex.valid <= 1'b0;
        end
    end

    a_no_load_store: assert property (@(posedge clk) disable iff (rst)
        id_ex.valid |-> !(id_ex.mem_read && id_ex.mem_write));

endmodule

// File: hazard_control.sv
`timescale 1ns/1ps

module hazard_control
    import cpu_pkg::*;
(
    input  if_id_t   if_id,
    input  id_ex_t   id_ex,
    input  ex_mem_t  ex_mem,
    input  mem_wb_t  mem_wb,
    input  logic     branch_taken,
    output logic     stall,
    output logic     flush,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b
);

    opcode_t   if_opcode;
    reg_addr_t if_rs1;
    reg_addr_t if_rs2;
    logic      uses_rs1;
    logic      uses_rs2;
    logic      load_in_ex;

    // Youngest matching producer wins
    function automatic fwd_sel_e pick_src(reg_addr_t rs, ex_mem_t em, mem_wb_t mw);
        if (rs != '0 && em.valid && em.reg_write && em.rd == rs) begin
            return FWD_EX_MEM;
        end
        if (rs != '0 && mw.valid && mw.reg_write && mw.rd == rs) begin
            return FWD_MEM_WB;
        end
        return FWD_REG;
    endfunction

    assign if_opcode = if_id.instr[6:0];
    assign if_rs1    = if_id.instr[19:15];
    assign if_rs2    = if_id.instr[24:20];

    // Only real source fields can create a load-use hazard
    assign uses_rs1 = if_id.valid && (if_opcode != OP_LUI);
    assign uses_rs2 = if_id.valid &&
                      (if_opcode inside {OP_REG, OP_STORE, OP_BRANCH});

    assign load_in_ex = id_ex.valid && id_ex.mem_read && (id_ex.rd != '0);

    assign stall = load_in_ex &&
                   ((uses_rs1 && if_rs1 == id_ex.rd) || (uses_rs2 && if_rs2 == id_ex.rd));

    assign flush = branch_taken;

    assign fwd_a = pick_src(id_ex.rs1, ex_mem, mem_wb);
    assign fwd_b = pick_src(id_ex.rs2, ex_mem, mem_wb);

    // A stalling load also writes a register and never meets a taken branch
    always_comb begin
        a_stall_on_load: assert final (stall !== 1'b1 ||
            (id_ex.valid && id_ex.mem_read && id_ex.reg_write && !id_ex.mem_write && !flush));
    end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  id_ex_t   id_ex,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  mem_wb_t  mem_wb,
    output ex_mem_t  ex_mem,
    output logic     branch_taken,
    output word_t    branch_target
);

    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t result;
    logic  operands_eq;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t ex_val,
                                      word_t wb_val);
        case (sel)
            FWD_EX_MEM: return ex_val;
            FWD_MEM_WB: return wb_val;
            default:    return reg_val;
        endcase
    endfunction

    assign op_a     = fwd_mux(fwd_a, id_ex.rd1, ex_mem.alu_result, mem_wb.wb_data);
    assign op_b_reg = fwd_mux(fwd_b, id_ex.rd2, ex_mem.alu_result, mem_wb.wb_data);
    assign op_b     = id_ex.alu_src_imm ? id_ex.imm : op_b_reg;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: result = op_b;
            default:    result = op_a + op_b;
        endcase
    end

    // Branches compare the two register operands and not the immediate
    assign operands_eq   = (op_a == op_b_reg);
    assign branch_taken  = id_ex.valid && id_ex.branch && (operands_eq ^ id_ex.branch_ne);
    assign branch_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        ex_mem.rd         <= id_ex.rd;
        ex_mem.alu_result <= result;
        ex_mem.store_data <= op_b_reg;
        ex_mem.mem_read   <= id_ex.mem_read;
        ex_mem.mem_write  <= id_ex.mem_write;
        ex_mem.reg_write  <= id_ex.reg_write;
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
        end
    end

endmodule

// File: memory_stage.sv
`timescale 1ns/1ps

module memory_stage
    import cpu_pkg::*;
#(
    parameter int DMEM_DEPTH = 256
) (
    input  logic    clk,
    input  logic    rst,
    input  ex_mem_t ex_mem,
    input  logic    dmem_we,
    input  word_t   dmem_addr,
    input  word_t   dmem_data,
    output logic    sync_wr,
    output word_t   sync_addr,
    output word_t   sync_data,
    output mem_wb_t mem_wb
);

    localparam int DA_W = $clog2(DMEM_DEPTH);

    word_t dmem [DMEM_DEPTH];
    word_t load_data;
    logic  store_en;

    assign store_en  = ex_mem.valid && ex_mem.mem_write;
    assign load_data = dmem[ex_mem.alu_result[DA_W+1:2]];

    // Preload port takes priority over stores
    always_ff @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[DA_W+1:2]] <= dmem_data;
        end else if (store_en) begin
            dmem[ex_mem.alu_result[DA_W+1:2]] <= ex_mem.store_data;
        end
    end

    // Store observation
    assign sync_wr   = store_en;
    assign sync_addr = ex_mem.alu_result;
    assign sync_data = ex_mem.store_data;

    always_ff @(posedge clk) begin
        mem_wb.rd        <= ex_mem.rd;
        mem_wb.wb_data   <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
        mem_wb.reg_write <= ex_mem.reg_write;
        if (rst) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid <= ex_mem.valid;
        end
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (rst)
        ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write)
            |-> ex_mem.alu_result[1:0] == 2'b00);

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top
    import cpu_pkg::*;
#(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  run,
    input  logic  imem_we,
    input  word_t imem_addr,
    input  word_t imem_data,
    input  logic  dmem_we,
    input  word_t dmem_addr,
    input  word_t dmem_data,
    output logic  sync_wr,
    output word_t sync_addr,
    output word_t sync_data
);

    // Stage registers
    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;

    // Pipeline control
    logic     stall;
    logic     flush;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     branch_taken;
    word_t    branch_target;

    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .clk(clk), .rst(rst), .run(run),
        .stall(stall), .flush(flush), .branch_target(branch_target),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
        .if_id(if_id)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .flush(flush), .stall(stall),
        .if_id(if_id), .mem_wb(mem_wb),
        .id_ex(id_ex)
    );

    hazard_control u_hazard (
        .if_id(if_id), .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
        .branch_taken(branch_taken),
        .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst), .id_ex(id_ex),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_wb(mem_wb),
        .ex_mem(ex_mem), .branch_taken(branch_taken), .branch_target(branch_target)
    );

    memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_memory (
        .clk(clk), .rst(rst), .ex_mem(ex_mem),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_data(dmem_data),
        .sync_wr(sync_wr), .sync_addr(sync_addr), .sync_data(sync_data),
        .mem_wb(mem_wb)
    );

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu
    import cpu_pkg::*;
();

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam int WAIT_LIMIT = 400;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic   clk;
    logic   rst;
    logic   run;
    logic   imem_we;
    word_t  imem_addr;
    word_t  imem_data;
    logic   dmem_we;
    word_t  dmem_addr;
    word_t  dmem_data;
    logic   sync_wr;
    word_t  sync_addr;
    word_t  sync_data;

    store_t expected_q[$];
    word_t  prog[$];
    logic   head_valid;
    word_t  head_addr;
    word_t  head_data;
    int     seed;

    cpu_top #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) DUT (
        .clk(clk), .rst(rst), .run(run),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_data(dmem_data),
        .sync_wr(sync_wr), .sync_addr(sync_addr), .sync_data(sync_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Instruction encoders
    function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t sw_instr(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t branch_instr(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                           logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "Simulation stopped after the first error");
    endtask

    task automatic report_store_error();
        if (!head_valid) begin
            $display("Unexpected store to address %h with data %h", sync_addr, sync_data);
        end else begin
            if (sync_addr != head_addr) begin
                $display("ERROR sync_addr: got %h expected %h", sync_addr, head_addr);
            end
            if (sync_data != head_data) begin
                $display("ERROR sync_data: got %h expected %h", sync_data, head_data);
            end
        end
        abort_run();
    endtask

    // Both checks sample at the falling edge while the outputs are stable
    a_store_matches: assert property (@(negedge clk) disable iff (rst)
        sync_wr |-> (head_valid && sync_addr == head_addr && sync_data == head_data))
        else report_store_error();

    a_quiet_when_idle: assert property (@(negedge clk) (rst || !run) |-> !sync_wr)
        else begin
            $display("sync_wr pulsed while the core was in reset or halted");
            abort_run();
        end

    task automatic refresh_head();
        head_valid = (expected_q.size() != 0);
        if (head_valid) begin
            head_addr = expected_q[0].addr;
            head_data = expected_q[0].data;
        end
    endtask

    task automatic push_store(input word_t addr, input word_t data);
        store_t entry;
        entry.addr = addr;
        entry.data = data;
        expected_q.push_back(entry);
        refresh_head();
    endtask

    task automatic write_dmem(input word_t addr, input word_t data);
        @(posedge clk);
        dmem_we   <= 1'b1;
        dmem_addr <= addr;
        dmem_data <= data;
        @(posedge clk);
        dmem_we <= 1'b0;
    endtask

    // Short reset returns the PC to zero before the whole imem is rewritten
    task automatic install_program();
        @(posedge clk);
        rst <= 1'b1;
        run <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= word_t'(i * 4);
            // Fill words past the program are ADDI x0 with the byte address as immediate
            imem_data <= (i < prog.size()) ? prog[i] :
                         i_type(12'(i * 4), 5'd0, 3'b000, 5'd0, OP_IMM);
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic run_program(input string name);
        int   cycles;
        logic store_seen;
        cycles = 0;
        @(posedge clk);
        run <= 1'b1;
        while (expected_q.size() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            store_seen = sync_wr;
            @(posedge clk);
            if (store_seen && expected_q.size() != 0) begin
                void'(expected_q.pop_front());
                refresh_head();
            end
        end
        if (expected_q.size() != 0) begin
            $display("Timed out in the %s program with %0d stores still missing",
                     name, expected_q.size());
            abort_run();
        end
        @(posedge clk);
        run <= 1'b0;
        // Trailing fill words drain out of the pipeline
        repeat (6) @(posedge clk);
    endtask

    task automatic alu_chain_program();
        logic [11:0] a_imm;
        logic [11:0] b_imm;
        logic [19:0] u_imm;
        word_t a;
        word_t b;
        word_t v_add;
        word_t v_sub;
        word_t v_and;
        word_t v_or;
        word_t v_xor;
        word_t v_slt;
        a_imm = 12'($random(seed));
        b_imm = 12'($random(seed));
        u_imm = 20'($random(seed));
        a = sext12(a_imm);
        b = sext12(b_imm);
        v_add = a + b;
        v_sub = a - v_add;
        v_and = v_sub & b;
        v_or  = v_and | a;
        v_xor = v_or ^ b;
        v_slt = ($signed(v_xor) < $signed(a)) ? 32'd1 : 32'd0;
        prog.delete();
        prog.push_back(i_type(a_imm, 5'd0, 3'b000, 5'd1, OP_IMM));
        prog.push_back(i_type(b_imm, 5'd0, 3'b000, 5'd2, OP_IMM));
        prog.push_back(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(sw_instr(12'd0, 5'd3, 5'd0));
        prog.push_back(r_type(7'b0100000, 5'd3, 5'd1, 3'b000, 5'd4));
        prog.push_back(sw_instr(12'd4, 5'd4, 5'd0));
        prog.push_back(r_type(7'b0000000, 5'd2, 5'd4, 3'b111, 5'd5));
        prog.push_back(sw_instr(12'd8, 5'd5, 5'd0));
        prog.push_back(r_type(7'b0000000, 5'd1, 5'd5, 3'b110, 5'd6));
        prog.push_back(sw_instr(12'd12, 5'd6, 5'd0));
        prog.push_back(r_type(7'b0000000, 5'd2, 5'd6, 3'b100, 5'd7));
        prog.push_back(sw_instr(12'd16, 5'd7, 5'd0));
        prog.push_back(r_type(7'b0000000, 5'd1, 5'd7, 3'b010, 5'd8));
        prog.push_back(sw_instr(12'd20, 5'd8, 5'd0));
        prog.push_back({u_imm, 5'd9, OP_LUI});
        prog.push_back(sw_instr(12'd24, 5'd9, 5'd0));
        install_program();
        push_store(32'h00, v_add);
        push_store(32'h04, v_sub);
        push_store(32'h08, v_and);
        push_store(32'h0c, v_or);
        push_store(32'h10, v_xor);
        push_store(32'h14, v_slt);
        push_store(32'h18, {u_imm, 12'h000});
        run_program("ALU chain");
    endtask

    task automatic load_use_program();
        logic [11:0] k_imm;
        word_t d;
        k_imm = 12'($random(seed));
        d = $random(seed);
        prog.delete();
        prog.push_back(i_type(12'h040, 5'd0, 3'b000, 5'd10, OP_IMM));
        prog.push_back(i_type(12'd0, 5'd10, 3'b010, 5'd11, OP_LOAD));
        prog.push_back(i_type(k_imm, 5'd11, 3'b000, 5'd12, OP_IMM));
        prog.push_back(sw_instr(12'd4, 5'd12, 5'd10));
        prog.push_back(sw_instr(12'd8, 5'd11, 5'd10));
        // Loaded value consumed as store data right away
        prog.push_back(i_type(12'd0, 5'd10, 3'b010, 5'd13, OP_LOAD));
        prog.push_back(sw_instr(12'd12, 5'd13, 5'd10));
        install_program();
        write_dmem(32'h40, d);
        push_store(32'h44, d + sext12(k_imm));
        push_store(32'h48, d);
        push_store(32'h4c, d);
        run_program("load-use");
    endtask

    task automatic taken_branch_program();
        logic [11:0] a_imm;
        word_t a;
        a_imm = 12'($random(seed));
        a = sext12(a_imm);
        prog.delete();
        prog.push_back(i_type(a_imm, 5'd0, 3'b000, 5'd1, OP_IMM));
        prog.push_back(i_type(a_imm, 5'd0, 3'b000, 5'd2, OP_IMM));
        prog.push_back(i_type(12'd1, 5'd1, 3'b000, 5'd3, OP_IMM));
        prog.push_back(branch_instr(13'd12, 5'd2, 5'd1, 3'b000));
        prog.push_back(sw_instr(12'h080, 5'd1, 5'd0));
        prog.push_back(sw_instr(12'h084, 5'd2, 5'd0));
        prog.push_back(sw_instr(12'h088, 5'd1, 5'd0));
        prog.push_back(branch_instr(13'd12, 5'd3, 5'd1, 3'b001));
        prog.push_back(sw_instr(12'h08c, 5'd3, 5'd0));
        prog.push_back(sw_instr(12'h090, 5'd3, 5'd0));
        prog.push_back(sw_instr(12'h094, 5'd3, 5'd0));
        install_program();
        push_store(32'h88, a);
        push_store(32'h94, a + 32'd1);
        run_program("taken branch");
    endtask

    task automatic untaken_branch_program();
        logic [11:0] a_imm;
        word_t a;
        a_imm = 12'($random(seed));
        a = sext12(a_imm);
        prog.delete();
        prog.push_back(i_type(a_imm, 5'd0, 3'b000, 5'd1, OP_IMM));
        prog.push_back(i_type(12'd5, 5'd1, 3'b000, 5'd2, OP_IMM));
        prog.push_back(branch_instr(13'd12, 5'd2, 5'd1, 3'b000));
        prog.push_back(sw_instr(12'h0a0, 5'd1, 5'd0));
        prog.push_back(sw_instr(12'h0a4, 5'd2, 5'd0));
        prog.push_back(branch_instr(13'd12, 5'd1, 5'd1, 3'b001));
        prog.push_back(sw_instr(12'h0a8, 5'd2, 5'd0));
        prog.push_back(sw_instr(12'h0ac, 5'd1, 5'd0));
        install_program();
        push_store(32'ha0, a);
        push_store(32'ha4, a + 32'd5);
        push_store(32'ha8, a + 32'd5);
        push_store(32'hac, a);
        run_program("untaken branch");
    endtask

    initial begin
        seed       = 32'h8037;
        rst        = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_data  = '0;
        dmem_we    = 1'b0;
        dmem_addr  = '0;
        dmem_data  = '0;
        head_valid = 1'b0;
        head_addr  = '0;
        head_data  = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // Idle a while with run low
        repeat (8) @(posedge clk);
        alu_chain_program();
        load_use_program();
        taken_branch_program();
        untaken_branch_program();
        $display("All checks passed");
        $finish;
    end

endmodule

// File: src.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
hazard_control.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_cpu -f src.f -o tb_cpu_sim
./obj_dir/tb_cpu_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
